/* design/fp_isa_pkg.sv */
//----------------------------------------------------------
// Instruction-set encodings for the FP non-computational slice
// Funct3 variant codes follow the RISC-V F/D extensions
// Flag positions follow the fflags CSR layout
//----------------------------------------------------------

package fp_isa_pkg;

   // Decoded instruction types handled by this slice
   typedef enum logic [3:0] {
      FSGNJ,
      FMIN_MAX,
      FCMP,
      FCLASS,
      FMV_X2F,
      FMV_F2X
   } fp_op_e;

   typedef enum logic {
      FMT_S,   // Single precision
      FMT_D    // Double precision
   } fp_fmt_e;

   // Funct3 variants
   localparam logic [2:0] FUNCT_J   = 3'b000;
   localparam logic [2:0] FUNCT_JN  = 3'b001;
   localparam logic [2:0] FUNCT_JX  = 3'b010;
   localparam logic [2:0] FUNCT_MIN = 3'b000;
   localparam logic [2:0] FUNCT_MAX = 3'b001;
   localparam logic [2:0] FUNCT_LE  = 3'b000;
   localparam logic [2:0] FUNCT_LT  = 3'b001;
   localparam logic [2:0] FUNCT_EQ  = 3'b010;

   // FCLASS result bits
   localparam int CLASS_NEG_INF  = 0;
   localparam int CLASS_NEG_NORM = 1;
   localparam int CLASS_NEG_SUB  = 2;
   localparam int CLASS_NEG_ZERO = 3;
   localparam int CLASS_POS_ZERO = 4;
   localparam int CLASS_POS_SUB  = 5;
   localparam int CLASS_POS_NORM = 6;
   localparam int CLASS_POS_INF  = 7;
   localparam int CLASS_SNAN     = 8;
   localparam int CLASS_QNAN     = 9;

   localparam int FLAGS_W = 5;
   localparam int FLAG_NV = 4;    // Invalid operation

endpackage

/* design/fp_unit_pkg.sv */
//----------------------------------------------------------
// Sizing constants and internal op codes of the FP slice
// QUEUE_DEPTH must be a power of two
//----------------------------------------------------------

package fp_unit_pkg;

   localparam int XLEN        = 64;
   localparam int REG_W       = 5;
   localparam int QUEUE_DEPTH = 4;
   localparam int EXEC_LAT    = 2;   // Decode register to execute output

   localparam int QPTR_W = $clog2(QUEUE_DEPTH);
   localparam int QCNT_W = $clog2(QUEUE_DEPTH + 1);

   // Operation seen by the execute pipeline
   typedef enum logic [2:0] {
      OP_SGNJ,
      OP_MINMAX,
      OP_CMP,
      OP_CLASS,
      OP_MOVE
   } exec_op_e;

endpackage

/* design/fp_decode.sv */
//----------------------------------------------------------
// Decode stage. The core must keep valid_i low while stall_i
// is high. A flush drops the instruction held in the register
//----------------------------------------------------------
`timescale 1ns/100ps

module fp_decode (
   input  logic                          clk_i,
   input  logic                          reset_i,
   input  logic                          flush_i,
   input  logic                          valid_i,
   input  fp_isa_pkg::fp_op_e            instr_type_i,
   input  fp_isa_pkg::fp_fmt_e           fmt_i,
   input  logic [2:0]                    funct_i,
   input  logic [fp_unit_pkg::REG_W-1:0] rd_i,
   input  logic [fp_unit_pkg::XLEN-1:0]  rs1_data_i,
   input  logic [fp_unit_pkg::XLEN-1:0]  rs2_data_i,
   input  logic                          stall_i,
   output logic                          accept_o,
   output logic                          dec_valid_o,
   output fp_unit_pkg::exec_op_e         dec_op_o,
   output fp_isa_pkg::fp_fmt_e           dec_fmt_o,
   output logic [2:0]                    dec_funct_o,
   output logic [fp_unit_pkg::REG_W-1:0] dec_rd_o,
   output logic                          dec_to_int_o,
   output logic [fp_unit_pkg::XLEN-1:0]  dec_a_o,
   output logic [fp_unit_pkg::XLEN-1:0]  dec_b_o
);

   import fp_isa_pkg::*;
   import fp_unit_pkg::*;

   exec_op_e        op_d;
   logic            to_int_d;
   logic [XLEN-1:0] a_d;

   assign accept_o = valid_i & ~stall_i;

   // Instruction type to internal op and destination file
   always_comb begin
      op_d     = OP_MOVE;
      to_int_d = 1'b0;
      a_d      = rs1_data_i;
      case (instr_type_i)
         FSGNJ:    op_d = OP_SGNJ;
         FMIN_MAX: op_d = OP_MINMAX;
         FCMP: begin
            op_d     = OP_CMP;
            to_int_d = 1'b1;
         end
         FCLASS: begin
            op_d     = OP_CLASS;
            to_int_d = 1'b1;
         end
         FMV_X2F:  op_d = OP_MOVE;
         FMV_F2X: begin
            op_d     = OP_MOVE;
            to_int_d = 1'b1;   // FP bits to integer file
         end
         default:  op_d = OP_MOVE;
      endcase
      if (op_d == OP_MOVE && fmt_i == FMT_S) begin
         a_d = {32'b0, rs1_data_i[31:0]};   // Only the low word moves
      end
   end

   always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
         dec_valid_o <= 1'b0;
      end else begin
         dec_valid_o <= accept_o;
      end
   end

   always_ff @(posedge clk_i) begin
      if (accept_o) begin
         dec_op_o     <= op_d;
         dec_fmt_o    <= fmt_i;
         dec_funct_o  <= funct_i;
         dec_rd_o     <= rd_i;
         dec_to_int_o <= to_int_d;
         dec_a_o      <= a_d;
         dec_b_o      <= rs2_data_i;
      end
   end

   // Issue must honour the queue's back-pressure
   a_no_issue_on_stall: assert property (
      @(posedge clk_i) disable iff (reset_i) stall_i |-> !valid_i
   ) else $error("valid_i raised while stall_i is high");

endmodule

/* design/fp_noncomp_exec.sv */
//----------------------------------------------------------
// Non-computational FP execute, fixed latency EXEC_LAT
// Single-precision operands are read from the low 32 bits
// with no NaN-boxing check
//----------------------------------------------------------
`timescale 1ns/100ps

module fp_noncomp_exec (
   input  logic                               clk_i,
   input  logic                               reset_i,
   input  logic                               flush_i,
   input  logic                               dec_valid_i,
   input  fp_unit_pkg::exec_op_e              dec_op_i,
   input  fp_isa_pkg::fp_fmt_e                dec_fmt_i,
   input  logic [2:0]                         dec_funct_i,
   input  logic [fp_unit_pkg::REG_W-1:0]      dec_rd_i,
   input  logic                               dec_to_int_i,
   input  logic [fp_unit_pkg::XLEN-1:0]       dec_a_i,
   input  logic [fp_unit_pkg::XLEN-1:0]       dec_b_i,
   output logic                               ex_valid_o,
   output logic [fp_unit_pkg::REG_W-1:0]      ex_rd_o,
   output logic                               ex_to_int_o,
   output logic [fp_unit_pkg::XLEN-1:0]       ex_data_o,
   output logic [fp_isa_pkg::FLAGS_W-1:0]     ex_flags_o
);

   import fp_isa_pkg::*;
   import fp_unit_pkg::*;

   typedef struct packed {
      logic sign;
      logic exp_ones;
      logic exp_zero;
      logic man_zero;
      logic quiet;
   } fp_info_t;

   function automatic fp_info_t unpack_op(input logic [XLEN-1:0] x, input fp_fmt_e fmt);
      fp_info_t info;
      if (fmt == FMT_S) begin
         info.sign     = x[31];
         info.exp_ones = &x[30:23];
         info.exp_zero = ~|x[30:23];
         info.man_zero = ~|x[22:0];
         info.quiet    = x[22];
      end else begin
         info.sign     = x[63];
         info.exp_ones = &x[62:52];
         info.exp_zero = ~|x[62:52];
         info.man_zero = ~|x[51:0];
         info.quiet    = x[51];
      end
      return info;
   endfunction

   //----------------------------------------------------------
   // Stage 1 operand unpack
   //----------------------------------------------------------
   logic [EXEC_LAT-1:0] vld_q;   // Valid shift, one bit per stage
   exec_op_e            s1_op;
   fp_fmt_e             s1_fmt;
   logic [2:0]          s1_funct;
   logic [REG_W-1:0]    s1_rd;
   logic                s1_to_int;
   logic [XLEN-1:0]     s1_a, s1_b;
   fp_info_t            s1_ia, s1_ib;

   always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
         vld_q <= '0;
      end else begin
         vld_q <= {vld_q[EXEC_LAT-2:0], dec_valid_i};
      end
   end

   always_ff @(posedge clk_i) begin
      if (dec_valid_i) begin
         s1_op     <= dec_op_i;
         s1_fmt    <= dec_fmt_i;
         s1_funct  <= dec_funct_i;
         s1_rd     <= dec_rd_i;
         s1_to_int <= dec_to_int_i;
         s1_a      <= dec_a_i;
         s1_b      <= dec_b_i;
         s1_ia     <= unpack_op(dec_a_i, dec_fmt_i);
         s1_ib     <= unpack_op(dec_b_i, dec_fmt_i);
      end
   end

   //----------------------------------------------------------
   // Stage 2 result
   //----------------------------------------------------------
   logic               a_nan, b_nan, a_snan, b_snan, both_zero;
   logic               lt_total, lt, eq, res_sign, nv;
   logic [62:0]        mag_a, mag_b;
   logic [XLEN-1:0]    canon_nan, raw, res;
   logic [9:0]         cls;
   logic [FLAGS_W-1:0] flags;

   always_comb begin
      a_nan     = s1_ia.exp_ones & ~s1_ia.man_zero;
      b_nan     = s1_ib.exp_ones & ~s1_ib.man_zero;
      a_snan    = a_nan & ~s1_ia.quiet;
      b_snan    = b_nan & ~s1_ib.quiet;
      both_zero = s1_ia.exp_zero & s1_ia.man_zero & s1_ib.exp_zero & s1_ib.man_zero;
      if (s1_fmt == FMT_S) begin
         mag_a     = {32'b0, s1_a[30:0]};
         mag_b     = {32'b0, s1_b[30:0]};
         canon_nan = {32'b0, 32'h7fc0_0000};
      end else begin
         mag_a     = s1_a[62:0];
         mag_b     = s1_b[62:0];
         canon_nan = 64'h7ff8_0000_0000_0000;
      end

      // Total order with -0 below +0
      if (s1_ia.sign != s1_ib.sign) begin
         lt_total = s1_ia.sign;
      end else if (s1_ia.sign) begin
         lt_total = mag_a > mag_b;
      end else begin
         lt_total = mag_a < mag_b;
      end
      lt = lt_total & ~both_zero;                    // IEEE compare sees +0 == -0
      eq = (mag_a == mag_b && s1_ia.sign == s1_ib.sign) || both_zero;

      cls = '0;
      if (a_nan) begin
         cls[s1_ia.quiet ? CLASS_QNAN : CLASS_SNAN] = 1'b1;
      end else if (s1_ia.exp_ones) begin
         cls[s1_ia.sign ? CLASS_NEG_INF : CLASS_POS_INF] = 1'b1;
      end else if (s1_ia.exp_zero && s1_ia.man_zero) begin
         cls[s1_ia.sign ? CLASS_NEG_ZERO : CLASS_POS_ZERO] = 1'b1;
      end else if (s1_ia.exp_zero) begin
         cls[s1_ia.sign ? CLASS_NEG_SUB : CLASS_POS_SUB] = 1'b1;
      end else begin
         cls[s1_ia.sign ? CLASS_NEG_NORM : CLASS_POS_NORM] = 1'b1;
      end

      raw      = '0;
      nv       = 1'b0;
      res_sign = s1_ib.sign;
      case (s1_op)
         OP_SGNJ: begin
            case (s1_funct)
               FUNCT_JN: res_sign = ~s1_ib.sign;
               FUNCT_JX: res_sign = s1_ia.sign ^ s1_ib.sign;
               default:  res_sign = s1_ib.sign;    // FUNCT_J
            endcase
            raw = s1_a;
            if (s1_fmt == FMT_S) begin
               raw[31] = res_sign;
            end else begin
               raw[63] = res_sign;
            end
         end
         OP_MINMAX: begin
            nv = a_snan | b_snan;
            if (a_nan && b_nan) begin
               raw = canon_nan;
            end else if (a_nan) begin
               raw = s1_b;
            end else if (b_nan) begin
               raw = s1_a;
            end else if ((s1_funct == FUNCT_MAX) ^ lt_total) begin
               raw = s1_a;
            end else begin
               raw = s1_b;
            end
         end
         OP_CMP: begin
            case (s1_funct)
               FUNCT_EQ: begin
                  nv     = a_snan | b_snan;          // Quiet compare
                  raw[0] = eq & ~(a_nan | b_nan);
               end
               FUNCT_LT: begin
                  nv     = a_nan | b_nan;            // Signalling compare
                  raw[0] = lt & ~(a_nan | b_nan);
               end
               FUNCT_LE: begin
                  nv     = a_nan | b_nan;
                  raw[0] = (lt | eq) & ~(a_nan | b_nan);
               end
               default: raw = '0;
            endcase
         end
         OP_CLASS: raw[9:0] = cls;
         default:  raw = s1_a;                       // OP_MOVE
      endcase

      // NaN-box FP results, sign-extend integer ones
      if (s1_fmt == FMT_D) begin
         res = raw;
      end else if (s1_to_int) begin
         res = {{32{raw[31]}}, raw[31:0]};
      end else begin
         res = {32'hffff_ffff, raw[31:0]};
      end
      flags          = '0;
      flags[FLAG_NV] = nv;
   end

   assign ex_valid_o = vld_q[EXEC_LAT-1];

   always_ff @(posedge clk_i) begin
      if (vld_q[0]) begin
         ex_rd_o     <= s1_rd;
         ex_to_int_o <= s1_to_int;
         ex_data_o   <= res;
         ex_flags_o  <= flags;
      end
   end

endmodule

/* design/fp_result_queue.sv */
//----------------------------------------------------------
// In-order result queue with slot reservation at issue
// Reservations cover in-flight work, so pushes never overflow
// Flush empties the buffer and clears every reservation
//----------------------------------------------------------
`timescale 1ns/100ps

module fp_result_queue (
   input  logic                           clk_i,
   input  logic                           reset_i,
   input  logic                           flush_i,
   input  logic                           accept_i,
   input  logic                           stall_wb_i,
   input  logic                           ex_valid_i,
   input  logic [fp_unit_pkg::REG_W-1:0]  ex_rd_i,
   input  logic                           ex_to_int_i,
   input  logic [fp_unit_pkg::XLEN-1:0]   ex_data_i,
   input  logic [fp_isa_pkg::FLAGS_W-1:0] ex_flags_i,
   output logic                           stall_o,
   output logic                           fp_wb_valid_o,
   output logic [fp_unit_pkg::REG_W-1:0]  fp_wb_rd_o,
   output logic [fp_unit_pkg::XLEN-1:0]   fp_wb_data_o,
   output logic [fp_isa_pkg::FLAGS_W-1:0] fp_wb_flags_o,
   output logic                           int_wb_valid_o,
   output logic [fp_unit_pkg::REG_W-1:0]  int_wb_rd_o,
   output logic [fp_unit_pkg::XLEN-1:0]   int_wb_data_o,
   output logic [fp_isa_pkg::FLAGS_W-1:0] int_wb_flags_o
);

   import fp_isa_pkg::*;
   import fp_unit_pkg::*;

   logic [REG_W-1:0]   mem_rd    [QUEUE_DEPTH];
   logic               mem_to_int[QUEUE_DEPTH];
   logic [XLEN-1:0]    mem_data  [QUEUE_DEPTH];
   logic [FLAGS_W-1:0] mem_flags [QUEUE_DEPTH];

   logic [QPTR_W-1:0] head_q, tail_q;
   logic [QCNT_W-1:0] count_q;   // Entries in the buffer
   logic [QCNT_W-1:0] resv_q;    // Accepted and not yet popped
   logic              head_valid, pop;

   assign head_valid = (count_q != '0);
   assign pop        = head_valid & ~stall_wb_i;
   assign stall_o    = (resv_q == QCNT_W'(QUEUE_DEPTH));

   always_ff @(posedge clk_i) begin
      if (reset_i || flush_i) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
         resv_q  <= '0;
      end else begin
         if (ex_valid_i) tail_q <= tail_q + QPTR_W'(1);
         if (pop)        head_q <= head_q + QPTR_W'(1);
         count_q <= count_q + QCNT_W'(ex_valid_i) - QCNT_W'(pop);
         resv_q  <= resv_q + QCNT_W'(accept_i) - QCNT_W'(pop);
      end
   end

   always_ff @(posedge clk_i) begin
      if (ex_valid_i) begin
         mem_rd[tail_q]     <= ex_rd_i;
         mem_to_int[tail_q] <= ex_to_int_i;
         mem_data[tail_q]   <= ex_data_i;
         mem_flags[tail_q]  <= ex_flags_i;
      end
   end

   // Head steering by destination file
   assign fp_wb_valid_o  = head_valid & ~mem_to_int[head_q];
   assign int_wb_valid_o = head_valid & mem_to_int[head_q];

   assign fp_wb_rd_o     = fp_wb_valid_o  ? mem_rd[head_q]    : '0;
   assign fp_wb_data_o   = fp_wb_valid_o  ? mem_data[head_q]  : '0;
   assign fp_wb_flags_o  = fp_wb_valid_o  ? mem_flags[head_q] : '0;
   assign int_wb_rd_o    = int_wb_valid_o ? mem_rd[head_q]    : '0;
   assign int_wb_data_o  = int_wb_valid_o ? mem_data[head_q]  : '0;
   assign int_wb_flags_o = int_wb_valid_o ? mem_flags[head_q] : '0;

   // Execute only delivers work that reserved a slot
   a_no_push_when_full: assert property (
      @(posedge clk_i) disable iff (reset_i) ex_valid_i |-> count_q != QCNT_W'(QUEUE_DEPTH)
   ) else $error("result pushed into a full queue");

   a_resv_no_underflow: assert property (
      @(posedge clk_i) disable iff (reset_i) pop |-> resv_q != '0
   ) else $error("reservation counter underflow");

endmodule

/* design/fp_unit_top.sv */
//----------------------------------------------------------
// FP non-computational slice. Accept to writeback is three
// cycles with an empty queue and no writeback stall
//----------------------------------------------------------
`timescale 1ns/100ps

module fp_unit_top (
   input  logic                           clk_i,
   input  logic                           reset_i,
   input  logic                           flush_i,
   input  logic                           valid_i,
   input  fp_isa_pkg::fp_op_e             instr_type_i,
   input  fp_isa_pkg::fp_fmt_e            fmt_i,
   input  logic [2:0]                     funct_i,
   input  logic [fp_unit_pkg::REG_W-1:0]  rd_i,
   input  logic [fp_unit_pkg::XLEN-1:0]   rs1_data_i,
   input  logic [fp_unit_pkg::XLEN-1:0]   rs2_data_i,
   input  logic                           stall_wb_i,
   output logic                           stall_o,
   output logic                           fp_wb_valid_o,
   output logic [fp_unit_pkg::REG_W-1:0]  fp_wb_rd_o,
   output logic [fp_unit_pkg::XLEN-1:0]   fp_wb_data_o,
   output logic [fp_isa_pkg::FLAGS_W-1:0] fp_wb_flags_o,
   output logic                           int_wb_valid_o,
   output logic [fp_unit_pkg::REG_W-1:0]  int_wb_rd_o,
   output logic [fp_unit_pkg::XLEN-1:0]   int_wb_data_o,
   output logic [fp_isa_pkg::FLAGS_W-1:0] int_wb_flags_o
);

   import fp_isa_pkg::*;
   import fp_unit_pkg::*;

   // Decode to execute
   logic               accept;
   logic               dec_valid;
   exec_op_e           dec_op;
   fp_fmt_e            dec_fmt;
   logic [2:0]         dec_funct;
   logic [REG_W-1:0]   dec_rd;
   logic               dec_to_int;
   logic [XLEN-1:0]    dec_a, dec_b;

   // Execute to queue
   logic               ex_valid;
   logic [REG_W-1:0]   ex_rd;
   logic               ex_to_int;
   logic [XLEN-1:0]    ex_data;
   logic [FLAGS_W-1:0] ex_flags;

   fp_decode i_decode (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .flush_i      (flush_i),
      .valid_i      (valid_i),
      .instr_type_i (instr_type_i),
      .fmt_i        (fmt_i),
      .funct_i      (funct_i),
      .rd_i         (rd_i),
      .rs1_data_i   (rs1_data_i),
      .rs2_data_i   (rs2_data_i),
      .stall_i      (stall_o),
      .accept_o     (accept),
      .dec_valid_o  (dec_valid),
      .dec_op_o     (dec_op),
      .dec_fmt_o    (dec_fmt),
      .dec_funct_o  (dec_funct),
      .dec_rd_o     (dec_rd),
      .dec_to_int_o (dec_to_int),
      .dec_a_o      (dec_a),
      .dec_b_o      (dec_b)
   );

   fp_noncomp_exec i_exec (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .flush_i      (flush_i),
      .dec_valid_i  (dec_valid),
      .dec_op_i     (dec_op),
      .dec_fmt_i    (dec_fmt),
      .dec_funct_i  (dec_funct),
      .dec_rd_i     (dec_rd),
      .dec_to_int_i (dec_to_int),
      .dec_a_i      (dec_a),
      .dec_b_i      (dec_b),
      .ex_valid_o   (ex_valid),
      .ex_rd_o      (ex_rd),
      .ex_to_int_o  (ex_to_int),
      .ex_data_o    (ex_data),
      .ex_flags_o   (ex_flags)
   );

   fp_result_queue i_queue (
      .clk_i          (clk_i),
      .reset_i        (reset_i),
      .flush_i        (flush_i),
      .accept_i       (accept),
      .stall_wb_i     (stall_wb_i),
      .ex_valid_i     (ex_valid),
      .ex_rd_i        (ex_rd),
      .ex_to_int_i    (ex_to_int),
      .ex_data_i      (ex_data),
      .ex_flags_i     (ex_flags),
      .stall_o        (stall_o),
      .fp_wb_valid_o  (fp_wb_valid_o),
      .fp_wb_rd_o     (fp_wb_rd_o),
      .fp_wb_data_o   (fp_wb_data_o),
      .fp_wb_flags_o  (fp_wb_flags_o),
      .int_wb_valid_o (int_wb_valid_o),
      .int_wb_rd_o    (int_wb_rd_o),
      .int_wb_data_o  (int_wb_data_o),
      .int_wb_flags_o (int_wb_flags_o)
   );

endmodule

/* bench/fp_unit_tb.sv */
//----------------------------------------------------------
// Testbench for the FP slice, run from the project root
// Vectors come from bench/fp_unit_stimulus.txt
// A vector with op f flushes the unit instead of issuing
// Work dropped by a flush is issued again after it
//----------------------------------------------------------
`timescale 1ns/100ps

module fp_unit_tb;

   import fp_isa_pkg::*;
   import fp_unit_pkg::*;

   localparam string      STIM_FILE = "bench/fp_unit_stimulus.txt";
   localparam logic [3:0] OP_FLUSH  = 4'hf;

   typedef struct packed {
      logic [3:0]         op;
      logic               fmt;
      logic [2:0]         funct;
      logic [REG_W-1:0]   rd;
      logic [XLEN-1:0]    rs1;
      logic [XLEN-1:0]    rs2;
      logic               to_int;   // Expected destination file
      logic [XLEN-1:0]    data;
      logic [FLAGS_W-1:0] flags;
   } vector_t;

   logic               clk_i, reset_i, flush_i, valid_i, stall_wb_i;
   fp_op_e             instr_type_i;
   fp_fmt_e            fmt_i;
   logic [2:0]         funct_i;
   logic [REG_W-1:0]   rd_i, fp_wb_rd_o, int_wb_rd_o;
   logic [XLEN-1:0]    rs1_data_i, rs2_data_i, fp_wb_data_o, int_wb_data_o;
   logic               stall_o, fp_wb_valid_o, int_wb_valid_o;
   logic [FLAGS_W-1:0] fp_wb_flags_o, int_wb_flags_o;

   vector_t     vectors[$];
   vector_t     exp_q[$];        // Results still owed by the DUT
   logic [31:0] lcg_state;
   int          resv_model;      // Accepted and not yet consumed
   int          cycle_cnt = 0;
   int          timeout_limit = 100;

   fp_unit_top i_dut (
      .clk_i (clk_i), .reset_i (reset_i), .flush_i (flush_i), .valid_i (valid_i),
      .instr_type_i (instr_type_i), .fmt_i (fmt_i), .funct_i (funct_i), .rd_i (rd_i),
      .rs1_data_i (rs1_data_i), .rs2_data_i (rs2_data_i), .stall_wb_i (stall_wb_i),
      .stall_o (stall_o),
      .fp_wb_valid_o (fp_wb_valid_o), .fp_wb_rd_o (fp_wb_rd_o),
      .fp_wb_data_o (fp_wb_data_o), .fp_wb_flags_o (fp_wb_flags_o),
      .int_wb_valid_o (int_wb_valid_o), .int_wb_rd_o (int_wb_rd_o),
      .int_wb_data_o (int_wb_data_o), .int_wb_flags_o (int_wb_flags_o)
   );

   always #50 clk_i = ~clk_i;

   // Run limit
   always @(posedge clk_i) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_limit) fail_run("Timeout, results stopped arriving");
   end

   task automatic fail_run(input string msg);
      $display("%s", msg);
      $display("Errors found");
      $fatal(1);
   endtask

   task automatic check_value(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
      assert (got === exp) else begin
         fail_run($sformatf("MISMATCH at %0t ns: %s got %h expected %h",
                            $time, name, got, exp));
      end
   endtask

   function automatic logic [31:0] next_rand();
      lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
      return lcg_state;
   endfunction

   task automatic load_vectors();
      int              fd;
      int              n;
      string           line;
      logic [XLEN-1:0] col[9];
      vector_t         v;
      fd = $fopen(STIM_FILE, "r");
      assert (fd != 0) else fail_run("Cannot open the stimulus file");
      while ($fgets(line, fd) != 0) begin
         if (line.len() < 2 || line[0] == "#") continue;   // Comment or blank
         n = $sscanf(line, "%h %h %h %h %h %h %h %h %h", col[0], col[1], col[2],
                     col[3], col[4], col[5], col[6], col[7], col[8]);
         if (n != 9) continue;
         v.op     = col[0][3:0];
         v.fmt    = col[1][0];
         v.funct  = col[2][2:0];
         v.rd     = col[3][REG_W-1:0];
         v.rs1    = col[4];
         v.rs2    = col[5];
         v.to_int = col[6][0];
         v.data   = col[7];
         v.flags  = col[8][FLAGS_W-1:0];
         vectors.push_back(v);
      end
      $fclose(fd);
   endtask

   task automatic issue(input vector_t v);
      valid_i      = 1'b1;
      instr_type_i = fp_op_e'(v.op);
      fmt_i        = fp_fmt_e'(v.fmt);
      funct_i      = v.funct;
      rd_i         = v.rd;
      rs1_data_i   = v.rs1;
      rs2_data_i   = v.rs2;
      exp_q.push_back(v);
      resv_model++;
   endtask

   // Outputs are stable here; a head with stall_wb_i low is consumed at the next edge
   task automatic check_head();
      vector_t exp;
      if ((fp_wb_valid_o || int_wb_valid_o) && !stall_wb_i) begin
         assert (exp_q.size() != 0) else fail_run("A result arrived with none expected");
         exp = exp_q.pop_front();
         resv_model--;
         check_value("fp_wb_valid_o", fp_wb_valid_o, !exp.to_int);
         check_value("int_wb_valid_o", int_wb_valid_o, exp.to_int);
         if (exp.to_int) begin
            check_value("int_wb_rd_o", int_wb_rd_o, exp.rd);
            check_value("int_wb_data_o", int_wb_data_o, exp.data);
            check_value("int_wb_flags_o", int_wb_flags_o, exp.flags);
            check_value("fp_wb_rd_o", fp_wb_rd_o, '0);       // Idle port reads zero
            check_value("fp_wb_data_o", fp_wb_data_o, '0);
            check_value("fp_wb_flags_o", fp_wb_flags_o, '0);
         end else begin
            check_value("fp_wb_rd_o", fp_wb_rd_o, exp.rd);
            check_value("fp_wb_data_o", fp_wb_data_o, exp.data);
            check_value("fp_wb_flags_o", fp_wb_flags_o, exp.flags);
            check_value("int_wb_rd_o", int_wb_rd_o, '0);
            check_value("int_wb_data_o", int_wb_data_o, '0);
            check_value("int_wb_flags_o", int_wb_flags_o, '0);
         end
      end
   endtask

   initial begin
      int   vec_idx;
      logic flushing;
      clk_i        = 1'b0;
      reset_i      = 1'b1;
      flush_i      = 1'b0;
      valid_i      = 1'b0;
      instr_type_i = FSGNJ;
      fmt_i        = FMT_S;
      funct_i      = '0;
      rd_i         = '0;
      rs1_data_i   = '0;
      rs2_data_i   = '0;
      stall_wb_i   = 1'b0;
      lcg_state    = 32'd97;
      resv_model   = 0;
      vec_idx      = 0;
      load_vectors();
      timeout_limit = 20 * vectors.size() + 100;

      repeat (5) @(negedge clk_i);
      reset_i = 1'b0;
      assert (!stall_o && !fp_wb_valid_o && !int_wb_valid_o)
         else fail_run("Outputs active after reset");

      //----------------------------------------------------------
      // Issue and drain
      //----------------------------------------------------------
      while (vec_idx < vectors.size() || exp_q.size() != 0) begin
         @(negedge clk_i);
         flush_i  = 1'b0;
         valid_i  = 1'b0;
         flushing = (vec_idx < vectors.size()) && (vectors[vec_idx].op == OP_FLUSH);
         stall_wb_i = flushing || (((next_rand() >> 16) % 3) == 0);
         check_value("stall_o", stall_o, resv_model == QUEUE_DEPTH);
         check_head();
         if (flushing) begin
            flush_i    = 1'b1;
            resv_model = 0;
            vec_idx++;
            // Dropped work issues again after the flush in its old order
            while (exp_q.size() != 0) begin
               vectors.insert(vec_idx, exp_q.pop_back());
            end
         end else if (vec_idx < vectors.size() && !stall_o) begin
            issue(vectors[vec_idx]);
            vec_idx++;
         end
      end

      // Any late extra result fails in check_head
      repeat (4) begin
         @(negedge clk_i);
         stall_wb_i = 1'b0;
         check_head();
      end
      if (!stall_o && !fp_wb_valid_o && !int_wb_valid_o) begin
         $display("No errors");
         $finish;
      end else begin
         fail_run("Unit not idle at the end of the test");
      end
   end

endmodule

/* bench/fp_unit_stimulus.txt */
# op fmt funct rd rs1 rs2 then expected to_int data flags, all hex
# op f flushes the unit and its other columns are ignored
0 0 0 01 ffffffff3f800000 ffffffffc0000000 0 ffffffffbf800000 00
0 0 1 02 0000000040400000 ffffffffc0000000 0 ffffffff40400000 00
0 0 2 03 ffffffffbf800000 ffffffffc0000000 0 ffffffff3f800000 00
0 1 0 04 3ff0000000000000 8000000000000000 0 bff0000000000000 00
0 1 2 05 c008000000000000 4000000000000000 0 c008000000000000 00
1 0 0 06 ffffffff3f800000 ffffffffc0000000 0 ffffffffc0000000 00
1 1 1 07 8000000000000000 0000000000000000 0 0000000000000000 00
1 1 1 08 4000000000000000 7ff0000000000001 0 4000000000000000 10
1 1 0 09 7ff8000000000000 fff8000000000000 0 7ff8000000000000 00
2 0 2 0a ffffffff3f800000 ffffffff3f800000 1 0000000000000001 00
2 0 2 0b ffffffff00000000 ffffffff80000000 1 0000000000000001 00
2 1 1 0c bff0000000000000 3ff0000000000000 1 0000000000000001 00
2 1 0 0d 7ff8000000000000 3ff0000000000000 1 0000000000000000 10
3 1 0 0e fff0000000000000 0000000000000000 1 0000000000000001 00
3 0 0 0f ffffffff00000001 0000000000000000 1 0000000000000020 00
3 1 0 10 7ff0000000000001 0000000000000000 1 0000000000000100 00
4 0 0 11 12345678deadbeef 0000000000000000 0 ffffffffdeadbeef 00
5 0 0 12 00000000c0490fdb 0000000000000000 1 ffffffffc0490fdb 00
f 0 0 00 0000000000000000 0000000000000000 0 0000000000000000 00
5 1 0 13 c00921fb54442d18 0000000000000000 1 c00921fb54442d18 00
1 0 0 14 ffffffff7fc00000 ffffffff40000000 0 ffffffff40000000 00

/* sources.f */
design/fp_isa_pkg.sv
design/fp_unit_pkg.sv
design/fp_decode.sv
design/fp_noncomp_exec.sv
design/fp_result_queue.sv
design/fp_unit_top.sv
bench/fp_unit_tb.sv

/* Makefile */
# Verilator flow for the FP non-computational slice
# Run from the project root, for example: make sim

VERILATOR ?= verilator
FILELIST  ?= sources.f
TB_TOP    ?= fp_unit_tb
RTL_TOP   ?= fp_unit_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

# The run passes only if the pass message appears as a line of its own
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP) 2>&1)"; echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
